/* design/game_pkg.sv */
package game_pkg;

  // xga timing, 1024x768 active
  localparam logic [10:0] HOR_PIXELS  = 11'd1024;
  localparam logic [10:0] VER_PIXELS  = 11'd768;
  localparam logic [10:0] HOR_TOTAL   = 11'd1344;
  localparam logic [10:0] VER_TOTAL   = 11'd806;

  // sync spans, start inclusive, stop exclusive
  localparam logic [10:0] HSYNC_START = 11'd1048;
  localparam logic [10:0] HSYNC_STOP  = 11'd1184;
  localparam logic [10:0] VSYNC_START = 11'd771;
  localparam logic [10:0] VSYNC_STOP  = 11'd777;

  // scene colours, 4 bits per channel
  localparam logic [11:0] BLUE_BG       = 12'h4_8_f;
  localparam logic [11:0] GREY_BAND     = 12'h7_7_7;
  localparam logic [11:0] GREEN_GRASS   = 12'h2_a_2;
  localparam logic [11:0] GREY_GOALPOST = 12'hc_c_c;
  localparam logic [11:0] WHITE_NET     = 12'hf_f_f;
  localparam logic [11:0] WHITE_LINES   = 12'he_e_e;
  localparam logic [11:0] BALL_COLOR    = 12'hf_8_0;

  // goal frame
  localparam logic [10:0] SH_POST_OUTER_EDGE      = 11'd192;
  localparam logic [10:0] SH_POST_INNER_EDGE      = 11'd208;
  localparam logic [10:0] SH_POST_TOP_EDGE        = 11'd250;
  localparam logic [10:0] SH_CROSSBAR_BOTTOM_EDGE = 11'd266;
  localparam logic [10:0] SH_POST_BOTTOM_EDGE     = 11'd520;

  // net mesh pitch
  localparam logic [10:0] SH_NET_WIDTH = 11'd16;

  // banner and grass
  localparam logic [10:0] SH_BANNER_TOP   = 11'd440;
  localparam logic [10:0] SH_GRASS_HEIGHT = 11'd480;

  // six-yard box
  localparam logic [10:0] SH_SIX_YARD_LINE_EDGE = 11'd112;
  localparam logic [10:0] SH_SIX_YARD_LINE      = 11'd600;
  localparam logic [10:0] SH_LINE_WIDTH         = 11'd5;

  // penalty spot, centred on the screen
  localparam logic [10:0] SH_SPOT_X = HOR_PIXELS / 2;
  localparam logic [10:0] SH_SPOT_Y = 11'd730;

  // stepped disc, three rectangles by half-width and half-height
  localparam logic [10:0] SH_SPOT_WIDE_HW = 11'd25;
  localparam logic [10:0] SH_SPOT_WIDE_HH = 11'd10;
  localparam logic [10:0] SH_SPOT_MID_HW  = 11'd20;
  localparam logic [10:0] SH_SPOT_MID_HH  = 11'd15;
  localparam logic [10:0] SH_SPOT_TALL_HW = 11'd15;
  localparam logic [10:0] SH_SPOT_TALL_HH = 11'd20;

  // square ball edge length
  localparam logic [10:0] BALL_SIZE = 11'd16;

endpackage

/* design/vga_if.sv */
`timescale 1ns/1ps

interface vga_if;

  logic [10:0] hcount;
  logic [10:0] vcount;
  logic        hsync;
  logic        vsync;
  logic        hblnk;
  logic        vblnk;
  logic [11:0] rgb;

  // producer side
  modport out (
    output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

  // consumer side
  modport in (
    input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
  );

endinterface

/* design/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
  input  logic clk,
  input  logic rst,
  vga_if.out   out
);

  logic [10:0] hcount_nxt;
  logic [10:0] vcount_nxt;
  logic        hblnk_nxt;
  logic        vblnk_nxt;
  logic        hsync_nxt;
  logic        vsync_nxt;

  // counter advance, vertical steps on horizontal wrap
  always_comb begin
    if (out.hcount == game_pkg::HOR_TOTAL - 11'd1) begin
      hcount_nxt = '0;
      if (out.vcount == game_pkg::VER_TOTAL - 11'd1) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = out.vcount + 11'd1;
      end
    end else begin
      hcount_nxt = out.hcount + 11'd1;
      vcount_nxt = out.vcount;
    end
  end

  // decode from the next values so everything lands in the same register stage
  always_comb begin
    hblnk_nxt = (hcount_nxt >= game_pkg::HOR_PIXELS);
    vblnk_nxt = (vcount_nxt >= game_pkg::VER_PIXELS);
    hsync_nxt = (hcount_nxt >= game_pkg::HSYNC_START) && (hcount_nxt < game_pkg::HSYNC_STOP);
    vsync_nxt = (vcount_nxt >= game_pkg::VSYNC_START) && (vcount_nxt < game_pkg::VSYNC_STOP);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
    end else begin
      out.hcount <= hcount_nxt;
      out.vcount <= vcount_nxt;
      out.hblnk  <= hblnk_nxt;
      out.vblnk  <= vblnk_nxt;
      out.hsync  <= hsync_nxt;
      out.vsync  <= vsync_nxt;
    end
  end

  // timing source carries no picture
  assign out.rgb = '0;

endmodule

/* design/draw_background.sv */
`timescale 1ns/1ps

module draw_background (
  input  logic clk,
  input  logic rst,
  vga_if.in    in,
  vga_if.out   out
);

  logic [11:0] rgb_nxt;
  logic [10:0] net_col_ofs;
  logic [10:0] net_row_ofs;
  logic        in_frame;
  logic        in_mouth;
  logic        on_net;
  logic        on_goal_line;
  logic        on_box;
  logic        on_spot;

  // offsets into the net mesh
  assign net_col_ofs = in.hcount - game_pkg::SH_POST_INNER_EDGE;
  assign net_row_ofs = in.vcount - game_pkg::SH_CROSSBAR_BOTTOM_EDGE;

  always_comb begin
    in_frame = (in.hcount >= game_pkg::SH_POST_OUTER_EDGE) &&
               (in.hcount < game_pkg::HOR_PIXELS - game_pkg::SH_POST_OUTER_EDGE) &&
               (in.vcount >= game_pkg::SH_POST_TOP_EDGE) &&
               (in.vcount < game_pkg::SH_POST_BOTTOM_EDGE);
    in_mouth = (in.hcount >= game_pkg::SH_POST_INNER_EDGE) &&
               (in.hcount < game_pkg::HOR_PIXELS - game_pkg::SH_POST_INNER_EDGE) &&
               (in.vcount > game_pkg::SH_CROSSBAR_BOTTOM_EDGE) &&
               (in.vcount < game_pkg::SH_POST_BOTTOM_EDGE);

    // vertical strands reach the grass row, horizontal ones stop just above it
    on_net = in_mouth &&
             (((net_col_ofs % game_pkg::SH_NET_WIDTH) == '0 &&
               in.vcount <= game_pkg::SH_GRASS_HEIGHT) ||
              ((net_row_ofs % game_pkg::SH_NET_WIDTH) == '0 &&
               in.vcount < game_pkg::SH_GRASS_HEIGHT));

    on_goal_line = (in.vcount >= game_pkg::SH_POST_BOTTOM_EDGE) &&
                   (in.vcount < game_pkg::SH_POST_BOTTOM_EDGE + game_pkg::SH_LINE_WIDTH);

    // box outline, inner hole cut out of the outer rectangle
    on_box = (in.hcount >= game_pkg::SH_SIX_YARD_LINE_EDGE) &&
             (in.hcount < game_pkg::HOR_PIXELS - game_pkg::SH_SIX_YARD_LINE_EDGE) &&
             (in.vcount >= game_pkg::SH_POST_BOTTOM_EDGE) &&
             (in.vcount < game_pkg::SH_SIX_YARD_LINE + game_pkg::SH_LINE_WIDTH) &&
             !((in.hcount >= game_pkg::SH_SIX_YARD_LINE_EDGE + game_pkg::SH_LINE_WIDTH) &&
               (in.hcount < game_pkg::HOR_PIXELS - game_pkg::SH_SIX_YARD_LINE_EDGE -
                            game_pkg::SH_LINE_WIDTH) &&
               (in.vcount < game_pkg::SH_SIX_YARD_LINE));

    // stepped disc from three overlapping rectangles
    on_spot =
      ((in.hcount >= game_pkg::SH_SPOT_X - game_pkg::SH_SPOT_WIDE_HW) &&
       (in.hcount <= game_pkg::SH_SPOT_X + game_pkg::SH_SPOT_WIDE_HW) &&
       (in.vcount >= game_pkg::SH_SPOT_Y - game_pkg::SH_SPOT_WIDE_HH) &&
       (in.vcount <= game_pkg::SH_SPOT_Y + game_pkg::SH_SPOT_WIDE_HH)) ||
      ((in.hcount >= game_pkg::SH_SPOT_X - game_pkg::SH_SPOT_MID_HW) &&
       (in.hcount <= game_pkg::SH_SPOT_X + game_pkg::SH_SPOT_MID_HW) &&
       (in.vcount >= game_pkg::SH_SPOT_Y - game_pkg::SH_SPOT_MID_HH) &&
       (in.vcount <= game_pkg::SH_SPOT_Y + game_pkg::SH_SPOT_MID_HH)) ||
      ((in.hcount >= game_pkg::SH_SPOT_X - game_pkg::SH_SPOT_TALL_HW) &&
       (in.hcount <= game_pkg::SH_SPOT_X + game_pkg::SH_SPOT_TALL_HW) &&
       (in.vcount >= game_pkg::SH_SPOT_Y - game_pkg::SH_SPOT_TALL_HH) &&
       (in.vcount <= game_pkg::SH_SPOT_Y + game_pkg::SH_SPOT_TALL_HH));
  end

  // first match wins, blanking always black
  always_comb begin
    if (in.hblnk || in.vblnk) begin
      rgb_nxt = '0;
    end else if (in_frame && !in_mouth) begin
      rgb_nxt = game_pkg::GREY_GOALPOST;
    end else if (on_net) begin
      rgb_nxt = game_pkg::WHITE_NET;
    end else if (on_goal_line || on_box || on_spot) begin
      rgb_nxt = game_pkg::WHITE_LINES;
    end else if (in.vcount >= game_pkg::SH_BANNER_TOP &&
                 in.vcount <= game_pkg::SH_GRASS_HEIGHT) begin
      rgb_nxt = game_pkg::GREY_BAND;
    end else if (in.vcount > game_pkg::SH_GRASS_HEIGHT) begin
      rgb_nxt = game_pkg::GREEN_GRASS;
    end else begin
      rgb_nxt = game_pkg::BLUE_BG;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out.hcount <= '0;
      out.vcount <= '0;
      out.hblnk  <= 1'b0;
      out.vblnk  <= 1'b0;
      out.hsync  <= 1'b0;
      out.vsync  <= 1'b0;
      out.rgb    <= '0;
    end else begin
      out.hcount <= in.hcount;
      out.vcount <= in.vcount;
      out.hblnk  <= in.hblnk;
      out.vblnk  <= in.vblnk;
      out.hsync  <= in.hsync;
      out.vsync  <= in.vsync;
      out.rgb    <= rgb_nxt;
    end
  end

endmodule

/* design/draw_ball.sv */
`timescale 1ns/1ps

module draw_ball (
  input  logic        clk,
  input  logic        rst,
  vga_if.in           in,
  input  logic [10:0] ball_x,
  input  logic [10:0] ball_y,
  input  logic        ball_we,
  output logic        hsync,
  output logic        vsync,
  output logic [11:0] rgb
);

  logic [10:0] pend_x;
  logic [10:0] pend_y;
  logic [10:0] act_x;
  logic [10:0] act_y;
  logic [11:0] ball_x_end;
  logic [11:0] ball_y_end;
  logic        frame_swap;
  logic        in_ball;

  // first line of vertical blanking, new position is safe to take
  assign frame_swap = (in.hcount == '0) && (in.vcount == game_pkg::VER_PIXELS);

  // latest write wins until the swap
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_x <= '0;
      pend_y <= '0;
      act_x  <= '0;
      act_y  <= '0;
    end else begin
      if (ball_we) begin
        pend_x <= ball_x;
        pend_y <= ball_y;
      end
      if (frame_swap) begin
        act_x <= pend_x;
        act_y <= pend_y;
      end
    end
  end

  // one extra bit so the far edge never wraps
  assign ball_x_end = {1'b0, act_x} + {1'b0, game_pkg::BALL_SIZE};
  assign ball_y_end = {1'b0, act_y} + {1'b0, game_pkg::BALL_SIZE};

  assign in_ball = !in.hblnk && !in.vblnk &&
                   (in.hcount >= act_x) && ({1'b0, in.hcount} < ball_x_end) &&
                   (in.vcount >= act_y) && ({1'b0, in.vcount} < ball_y_end);

  always_ff @(posedge clk) begin
    if (rst) begin
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end else begin
      hsync <= in.hsync;
      vsync <= in.vsync;
      rgb   <= in_ball ? game_pkg::BALL_COLOR : in.rgb;
    end
  end

endmodule

/* design/shooter_display.sv */
`timescale 1ns/1ps

module shooter_display (
  input  logic        clk,
  input  logic        rst,
  input  logic [10:0] ball_x,
  input  logic [10:0] ball_y,
  input  logic        ball_we,
  output logic        hsync,
  output logic        vsync,
  output logic [11:0] rgb
);

  // timing -> background -> ball
  vga_if tim ();
  vga_if bg ();

  vga_timing vga_timing_inst (
    .clk (clk),
    .rst (rst),
    .out (tim.out)
  );

  draw_background draw_background_inst (
    .clk (clk),
    .rst (rst),
    .in  (tim.in),
    .out (bg.out)
  );

  // ball overlay also retimes sync to match the picture
  draw_ball draw_ball_inst (
    .clk     (clk),
    .rst     (rst),
    .in      (bg.in),
    .ball_x  (ball_x),
    .ball_y  (ball_y),
    .ball_we (ball_we),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

endmodule

/* verif/shooter_display_tb.sv */
`timescale 1ns/1ps

module shooter_display_tb;

  logic        clk;
  logic        rst;
  logic [10:0] ball_x;
  logic [10:0] ball_y;
  logic        ball_we;
  logic        hsync;
  logic        vsync;
  logic [11:0] rgb;

  integer seed;
  int     hsync_errors;
  int     vsync_errors;
  int     rgb_errors;
  int     other_errors;
  logic   timed_out;

  // model state, h and v name the pixel now on the outputs
  int h;
  int v;
  int frames;
  int pend_x;
  int pend_y;
  int act_x;
  int act_y;
  int wr_a_v;
  int wr_a_h;
  int wr_b_v;
  int wr_b_h;

  shooter_display shooter_display_inst (
    .clk     (clk),
    .rst     (rst),
    .ball_x  (ball_x),
    .ball_y  (ball_y),
    .ball_we (ball_we),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  // one rectangle of the stepped penalty spot, centre (512, 730)
  function automatic logic spot_rect(input int x, input int y, input int hw, input int hh);
    return (x >= 512 - hw) && (x <= 512 + hw) && (y >= 730 - hh) && (y <= 730 + hh);
  endfunction

  function automatic logic [11:0] scene_color(input int x, input int y);
    logic on_frame;
    logic mouth;
    logic net;
    logic box;
    logic line;
    on_frame = (x >= 192) && (x < 832) && (y >= 250) && (y < 520);
    // opening between the posts, under the crossbar
    mouth = (x >= 208) && (x < 816) && (y > 266) && (y < 520);
    net = mouth && (((((x - 208) % 16) == 0) && (y <= 480)) ||
                    ((((y - 266) % 16) == 0) && (y < 480)));
    box = (x >= 112) && (x < 912) && (y >= 520) && (y < 605) &&
          !((x >= 117) && (x < 907) && (y < 600));
    line = ((y >= 520) && (y < 525)) || box || spot_rect(x, y, 25, 10) ||
           spot_rect(x, y, 20, 15) || spot_rect(x, y, 15, 20);
    if (on_frame && !mouth) return game_pkg::GREY_GOALPOST;
    if (net) return game_pkg::WHITE_NET;
    if (line) return game_pkg::WHITE_LINES;
    if ((y >= 440) && (y <= 480)) return game_pkg::GREY_BAND;
    if (y > 480) return game_pkg::GREEN_GRASS;
    return game_pkg::BLUE_BG;
  endfunction

  // one write early in the frame, a second one later in the first full frame
  // and sometimes after
  task automatic plan_writes();
    wr_a_v = rand_below(350);
    wr_a_h = rand_below(1344);
    wr_b_v = -1;
    wr_b_h = rand_below(1344);
    if (frames == 1 || rand_below(2) == 1) begin
      wr_b_v = 350 + rand_below(350);
    end
  endtask

  task automatic drive_writes();
    ball_we = 1'b0;
    if ((v == wr_a_v && h == wr_a_h) || (v == wr_b_v && h == wr_b_h)) begin
      ball_x  = 11'(rand_below(1009));
      ball_y  = 11'(rand_below(753));
      ball_we = 1'b1;
      pend_x  = int'(ball_x);
      pend_y  = int'(ball_y);
    end
  endtask

  task automatic check_zero(input string name, input logic [11:0] got);
    if (got !== 12'h000) begin
      other_errors++;
      $display("[FAIL] %s before first sync: expected 000, got %h", name, got);
    end
  endtask

  task automatic check_pixel();
    logic        exp_hs;
    logic        exp_vs;
    logic [11:0] exp_rgb;
    exp_hs = (h >= 1048) && (h < 1184);
    exp_vs = (v >= 771) && (v < 777);
    if (h >= 1024 || v >= 768) begin
      exp_rgb = 12'h000;
    end else if (h >= act_x && h < act_x + 16 && v >= act_y && v < act_y + 16) begin
      exp_rgb = game_pkg::BALL_COLOR;
    end else begin
      exp_rgb = scene_color(h, v);
    end
    // only the first few of each kind are printed
    if (hsync !== exp_hs) begin
      hsync_errors++;
      if (hsync_errors <= 10)
        $display("[FAIL] hsync at (%0d,%0d): expected %h, got %h", h, v, exp_hs, hsync);
    end
    if (vsync !== exp_vs) begin
      vsync_errors++;
      if (vsync_errors <= 10)
        $display("[FAIL] vsync at (%0d,%0d): expected %h, got %h", h, v, exp_vs, vsync);
    end
    if (rgb !== exp_rgb) begin
      rgb_errors++;
      if (rgb_errors <= 10)
        $display("[FAIL] rgb at (%0d,%0d): expected %h, got %h", h, v, exp_rgb, rgb);
    end
  endtask

  task automatic advance();
    h++;
    if (h == 1344) begin
      h = 0;
      v++;
      if (v == 806) begin
        v = 0;
        frames++;
        plan_writes();
      end
    end
    // new position taken on the first blanked line
    if (h == 0 && v == 768) begin
      act_x = pend_x;
      act_y = pend_y;
    end
  endtask

  // counters start at (0,0), hsync leaves 2 cycles after count 1048
  task automatic wait_first_hsync();
    int n;
    n = 0;
    while (hsync !== 1'b1 && n < 2000) begin
      @(negedge clk);
      n++;
      check_zero("vsync", 12'(vsync));
    end
    if (hsync !== 1'b1) begin
      other_errors++;
      timed_out = 1'b1;
      $display("Timed out waiting for the first horizontal sync pulse.");
    end else if (n != 1050) begin
      other_errors++;
      $display("First hsync rise came %0d cycles after reset, expected 1050.", n);
    end
  endtask

  task automatic wait_vsync_rise();
    int n;
    n = 0;
    while (vsync !== 1'b1 && n < 2 * 1344 * 806) begin
      @(negedge clk);
      n++;
    end
    if (vsync !== 1'b1) begin
      other_errors++;
      timed_out = 1'b1;
      $display("Timed out waiting for the first vertical sync pulse.");
    end
  endtask

  // first vsync rise is pixel (0, 771), then three full frames
  task automatic run_frames();
    int guard;
    h = 0;
    v = 771;
    frames = 0;
    guard = 0;
    while (frames < 4 && !timed_out) begin
      check_pixel();
      drive_writes();
      @(negedge clk);
      advance();
      guard++;
      if (guard > 5 * 1344 * 806) begin
        other_errors++;
        timed_out = 1'b1;
        $display("Timed out while checking frames.");
      end
    end
    ball_we = 1'b0;
  endtask

  initial begin
    seed = 32'h6b28_9033;
    rst = 1'b1;
    ball_x = '0;
    ball_y = '0;
    ball_we = 1'b0;
    hsync_errors = 0;
    vsync_errors = 0;
    rgb_errors = 0;
    other_errors = 0;
    timed_out = 1'b0;
    pend_x = 0;
    pend_y = 0;
    act_x = 0;
    act_y = 0;
    wr_a_v = -1;
    wr_a_h = -1;
    wr_b_v = -1;
    wr_b_h = -1;
    repeat (10) begin
      @(negedge clk);
      check_zero("hsync", 12'(hsync));
      check_zero("vsync", 12'(vsync));
      check_zero("rgb", rgb);
    end
    rst = 1'b0;
    wait_first_hsync();
    if (!timed_out) wait_vsync_rise();
    if (!timed_out) run_frames();
    $display("errors: hsync %0d, vsync %0d, rgb %0d, other %0d",
             hsync_errors, vsync_errors, rgb_errors, other_errors);
    if (hsync_errors + vsync_errors + rgb_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* shooter_display.f */
design/game_pkg.sv
design/vga_if.sv
design/vga_timing.sv
design/draw_background.sv
design/draw_ball.sv
design/shooter_display.sv
verif/shooter_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the shooter display testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  -f shooter_display.f \
  --top-module shooter_display_tb \
  -o sim_shooter_display

output=$(./obj_dir/sim_shooter_display)
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1
